//--- Makefile
# Verilator build and run for the integer divide unit

VERILATOR ?= verilator
TOP       ?= intDivTb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG TIMESCALE VFLAGS"

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q -F '>>> PASS' $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- common/divPkg.sv
`default_nettype none

package divPkg;

  //////////////////////////////
  // Widths
  //////////////////////////////
  parameter int DefaultXlen = 32;   // Data width of the core
  parameter int MaxCntWidth = 7;    // Covers counts up to 64

  // Lz counts, iteration counts, shift amounts
  typedef logic [MaxCntWidth-1:0] cntT;

  //////////////////////////////
  // Control bundles
  //////////////////////////////

  // Request side op decode
  typedef struct packed {
    logic isRem;      // Remainder wanted
    logic isSigned;   // Operands are two's complement
  } divCtrlT;

  // Carried from preprocessing to postprocessing
  typedef struct packed {
    logic isRem;
    logic negQuot;    // Signs differ on a signed op
    logic negRem;     // Negative dividend on a signed op
    logic bZero;      // Divisor is zero
    logic aLtB;       // More leading zeros in |A| than |B|
  } postCtrlT;

  // Sequencer states
  typedef enum logic [2:0] {
    Idle,             // Waiting for a request
    Prep,             // Normalize operands
    Iter,             // Digit recurrence
    Post,             // Correct and register result
    Hold              // Result offered on rsp port
  } divStateT;

endpackage : divPkg

`default_nettype wire

//--- divider/divFsm.sv
`default_nettype none

module divFsm import divPkg::*; (
  input  logic clk,
  input  logic rstN,
  input  logic reqValid,
  output logic reqReady,
  output logic rspValid,
  input  logic rspReady,
  input  cntT  iterCnt,
  input  logic special,       // Divide by zero or small dividend
  input  logic wZero,         // Residual exactly zero
  output logic capture,
  output logic load,
  output logic step,
  output logic outLoad,
  output cntT  remCnt         // Steps left, quotient scale
);

  divStateT state, stateNext;
  cntT      cnt;

  //////////////////////////////
  // Next state
  //////////////////////////////
  always_comb begin
    stateNext = state;
    case (state)
      Idle: if (reqValid) stateNext = Prep;
      Prep: stateNext = special ? Post : Iter;  // Specials skip the loop
      Iter: begin
        if (wZero)                  stateNext = Post;  // Exact, stop early
        else if (cnt == cntT'(1))   stateNext = Post;  // Last digit this cycle
      end
      Post: stateNext = Hold;
      Hold: if (rspReady) stateNext = Idle;
      default: stateNext = Idle;
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= Idle;
      cnt   <= '0;
    end else begin
      state <= stateNext;
      if (load)      cnt <= iterCnt;
      else if (step) cnt <= cnt - cntT'(1);
    end
  end

  // Handshakes and datapath strobes
  assign reqReady = (state == Idle);
  assign capture  = reqValid & reqReady;
  assign load     = (state == Prep);
  assign step     = (state == Iter) & ~wZero;
  assign outLoad  = (state == Post);
  assign rspValid = (state == Hold);
  assign remCnt   = cnt;

endmodule : divFsm

`default_nettype wire

//--- divider/divIterator.sv
`default_nettype none

module divIterator import divPkg::*; #(
  parameter int XLEN = DefaultXlen,
  localparam int ResW = XLEN + 5      // Q4.(XLEN+1)
) (
  input  logic            clk,
  input  logic            rstN,
  input  logic            load,
  input  logic            step,
  input  logic [ResW-1:0] xNorm,
  input  logic [ResW-1:0] dNorm,
  output logic [ResW-1:0] ws,         // Residual sum part
  output logic [ResW-1:0] wc,         // Residual carry part
  output logic [XLEN:0]   firstU,     // Quotient so far
  output logic [XLEN:0]   firstUM     // Quotient so far minus one
);

  logic [ResW-1:0] wsSh, wcSh;
  logic [ResW-1:0] dSel;
  logic [ResW-1:0] maj;
  logic [ResW-1:0] sumNext, carryNext;
  logic [3:0]      est;
  logic            qPos, qZero, qNeg;
  logic [XLEN:0]   uNext, umNext;

  //////////////////////////////
  // Digit selection
  //////////////////////////////
  assign wsSh = {ws[ResW-2:0], 1'b0};     // 2w
  assign wcSh = {wc[ResW-2:0], 1'b0};

  // Estimate of 2w, three integer bits and one fraction bit
  assign est = wsSh[ResW-2:ResW-5] + wcSh[ResW-2:ResW-5];

  assign qZero = (est == 4'b1111);        // Estimate is -1/2
  assign qPos  = ~est[3];                 // Estimate >= 0
  assign qNeg  = est[3] & ~qZero;         // Estimate <= -1

  //////////////////////////////
  // Carry-save update
  //////////////////////////////

  // q=+1 subtracts D as ~D plus carry in, q=-1 adds D
  always_comb begin
    if (qPos)      dSel = ~dNorm;
    else if (qNeg) dSel = dNorm;
    else           dSel = '0;
  end

  // 3:2 compressor row
  assign sumNext   = wsSh ^ wcSh ^ dSel;
  assign maj       = (wsSh & wcSh) | (wsSh & dSel) | (wcSh & dSel);
  assign carryNext = {maj[ResW-2:0], qPos}; // LSB free since 2w ends in zero

  //////////////////////////////
  // On-the-fly conversion
  //////////////////////////////
  always_comb begin
    if (qPos) begin
      uNext  = {firstU[XLEN-1:0], 1'b1};
      umNext = {firstU[XLEN-1:0], 1'b0};
    end else if (qZero) begin
      uNext  = {firstU[XLEN-1:0], 1'b0};
      umNext = {firstUM[XLEN-1:0], 1'b1};
    end else begin
      uNext  = {firstUM[XLEN-1:0], 1'b1};  // Borrow from U-1
      umNext = {firstUM[XLEN-1:0], 1'b0};
    end
  end

  //////////////////////////////
  // State
  //////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ws      <= '0;
      wc      <= '0;
      firstU  <= '0;
      firstUM <= '1;
    end else if (load) begin
      ws      <= xNorm;                   // w0 = X/2
      wc      <= '0;
      firstU  <= '0;
      firstUM <= '1;                      // Zero minus one
    end else if (step) begin
      ws      <= sumNext;
      wc      <= carryNext;
      firstU  <= uNext;
      firstUM <= umNext;
    end
  end

endmodule : divIterator

`default_nettype wire

//--- divider/divPostproc.sv
`default_nettype none

module divPostproc import divPkg::*; #(
  parameter int XLEN = DefaultXlen,
  localparam int ResW = XLEN + 5      // Q4.(XLEN+1)
) (
  input  logic            clk,
  input  logic            rstN,
  input  logic            outLoad,
  input  logic [ResW-1:0] ws,
  input  logic [ResW-1:0] wc,
  input  logic [ResW-1:0] dNorm,
  input  logic [XLEN:0]   firstU,
  input  logic [XLEN:0]   firstUM,
  input  postCtrlT        post,
  input  logic [XLEN-1:0] aSaved,
  input  cntT             normShift,
  input  cntT             remCnt,
  output logic            wZero,
  output logic [XLEN-1:0] result
);

  logic [ResW-1:0] wSum;
  logic [ResW-1:0] remCorr, remShift;
  logic            negSticky;
  logic [XLEN:0]   quotSel, quotShift;
  logic [XLEN-1:0] magSel, signedRes;
  logic [XLEN-1:0] resNext;
  logic            doNeg;

  //////////////////////////////
  // Residual resolve
  //////////////////////////////
  assign wSum      = ws + wc;
  assign wZero     = (wSum == '0);        // Early termination
  assign negSticky = wSum[ResW-1];        // Residual below zero

  //////////////////////////////
  // Quotient and remainder
  //////////////////////////////

  // Negative residual means one too many
  assign quotSel   = negSticky ? firstUM : firstU;
  assign quotShift = quotSel << remCnt;   // Digits skipped on early exit

  // Add divisor back, then undo divisor normalization
  assign remCorr  = negSticky ? wSum + dNorm : wSum;
  assign remShift = remCorr >> normShift;

  assign magSel    = post.isRem ? remShift[XLEN-1:0] : quotShift[XLEN-1:0];
  assign doNeg     = post.isRem ? post.negRem : post.negQuot;
  assign signedRes = doNeg ? -magSel : magSel;

  //////////////////////////////
  // Special cases
  //////////////////////////////
  always_comb begin
    if (post.bZero) begin
      if (post.isRem) resNext = aSaved;   // Remainder is the dividend
      else            resNext = '1;       // All ones quotient
    end else if (post.aLtB) begin
      if (post.isRem) resNext = aSaved;
      else            resNext = '0;
    end else begin
      resNext = signedRes;
    end
  end

  // Result register, held through Hold
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      result <= '0;
    end else if (outLoad) begin
      result <= resNext;
    end
  end

endmodule : divPostproc

`default_nettype wire

//--- divider/divPreproc.sv
`default_nettype none

module divPreproc import divPkg::*; #(
  parameter int XLEN = DefaultXlen,
  localparam int ResW = XLEN + 5      // Q4.(XLEN+1) residual
) (
  input  logic            clk,
  input  logic            rstN,
  input  logic            capture,
  input  logic [XLEN-1:0] a,
  input  logic [XLEN-1:0] b,
  input  divCtrlT         ctrl,
  output logic [ResW-1:0] xNorm,      // Initial residual, X/2
  output logic [ResW-1:0] dNorm,      // Divisor in [1/2, 1)
  output cntT             iterCnt,
  output cntT             normShift,  // Remainder scaling
  output logic            special,
  output postCtrlT        post,
  output logic [XLEN-1:0] aSaved      // Dividend as given
);

  logic            aNeg, bNeg;
  logic [XLEN-1:0] aAbsIn, bAbsIn;
  logic [XLEN-1:0] aAbs, bAbs;
  logic [XLEN-1:0] xShift, dShift;
  cntT             lzAIn, lzBIn;
  cntT             lzA, lzB;

  // Leading zero count, XLEN for a zero input
  function automatic cntT lzc(input logic [XLEN-1:0] v);
    cntT  n;
    logic found;
    n = '0;
    found = 1'b0;
    for (int i = XLEN - 1; i >= 0; i--) begin
      if (!found) begin
        if (v[i]) found = 1'b1;
        else      n = n + cntT'(1);
      end
    end
    return n;
  endfunction

  //////////////////////////////
  // Capture cycle
  //////////////////////////////
  assign aNeg   = ctrl.isSigned & a[XLEN-1];
  assign bNeg   = ctrl.isSigned & b[XLEN-1];
  assign aAbsIn = aNeg ? -a : a;           // Most negative stays as 2^(XLEN-1)
  assign bAbsIn = bNeg ? -b : b;
  assign lzAIn  = lzc(aAbsIn);
  assign lzBIn  = lzc(bAbsIn);

  // Control and counts
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      lzA  <= '0;
      lzB  <= '0;
      post <= '0;
    end else if (capture) begin
      lzA          <= lzAIn;
      lzB          <= lzBIn;
      post.isRem   <= ctrl.isRem;
      post.negQuot <= aNeg ^ bNeg;
      post.negRem  <= aNeg;
      post.bZero   <= (b == '0);
      post.aLtB    <= (lzAIn > lzBIn);  // Also true for a zero dividend
    end
  end

  // Operand payload
  always_ff @(posedge clk) begin
    if (capture) begin
      aAbs   <= aAbsIn;
      bAbs   <= bAbsIn;
      aSaved <= a;
    end
  end

  //////////////////////////////
  // Normalization in Prep
  //////////////////////////////
  assign xShift    = aAbs << lzA;         // Leading one at MSB
  assign dShift    = bAbs << lzB;
  assign xNorm     = {5'b0, xShift};      // 0.0 1xxx
  assign dNorm     = {4'b0, dShift, 1'b0}; // 0.1xxx
  assign iterCnt   = lzB - lzA + cntT'(1); // Quotient bit count
  assign normShift = lzB + cntT'(1);
  assign special   = post.bZero | post.aLtB;

endmodule : divPreproc

`default_nettype wire

//--- test/div_trace.txt
# name a b isRem isSigned expected
# a, b and expected in hex, isRem and isSigned are 0 or 1
divu_mix100   00000064 00000007 0 0 0000000e
remu_mix100   00000064 00000007 1 0 00000002
divu_allones  ffffffff 00000010 0 0 0fffffff
remu_allones  ffffffff 00000010 1 0 0000000f
divu_wide     12345678 00001234 0 0 00010004
remu_wide     12345678 00001234 1 0 00000da8
divu_msb      80000000 00000003 0 0 2aaaaaaa
remu_msb      80000000 00000003 1 0 00000002
divu_same     deadbeef deadbeef 0 0 00000001
divu_near     fffffffe ffffffff 0 0 00000000
remu_near     fffffffe ffffffff 1 0 fffffffe
divu_byone    ffffffff 00000001 0 0 ffffffff
divu_exact    00010000 00000100 0 0 00000100
remu_exact    00010000 00000100 1 0 00000000
div_pp        00000007 00000002 0 1 00000003
rem_pp        00000007 00000002 1 1 00000001
div_np        fffffff9 00000002 0 1 fffffffd
rem_np        fffffff9 00000002 1 1 ffffffff
div_pn        00000007 fffffffe 0 1 fffffffd
rem_pn        00000007 fffffffe 1 1 00000001
div_nn        fffffff9 fffffffe 0 1 00000003
rem_nn        fffffff9 fffffffe 1 1 ffffffff
div_neg100    ffffff9c 00000007 0 1 fffffff2
rem_neg100    ffffff9c 00000007 1 1 fffffffe
div_big       000f4240 fffffffd 0 1 fffae9eb
rem_big       000f4240 fffffffd 1 1 00000001
div_exact     fffffff4 fffffffc 0 1 00000003
rem_exact     fffffff4 fffffffc 1 1 00000000
div_minby2    80000000 00000002 0 1 c0000000
divu_zero     12345678 00000000 0 0 ffffffff
remu_zero     12345678 00000000 1 0 12345678
div_zero      fffffffb 00000000 0 1 ffffffff
rem_zero      fffffffb 00000000 1 1 fffffffb
div_ovf       80000000 ffffffff 0 1 80000000
rem_ovf       80000000 ffffffff 1 1 00000000
divu_small    00000005 00000009 0 0 00000000
remu_small    00000005 00000009 1 0 00000005
rem_small     fffffffb 00000009 1 1 fffffffb
divu_zerodvd  00000000 00000007 0 0 00000000
rem_minb      00000003 80000000 1 1 00000003

//--- test/intDivTb.sv
`default_nettype none

module intDivTb import divPkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int Xlen       = 32;
  localparam int NameW      = 8 * 24;   // Test names up to 24 chars
  localparam int ReqTimeout = 20;       // Cycles to wait for reqReady
  localparam int RspTimeout = 300;      // Iterations plus stalls

  logic            clk;
  logic            rstN;
  logic            reqValid;
  logic            reqReady;
  logic [Xlen-1:0] reqA;
  logic [Xlen-1:0] reqB;
  divCtrlT         reqCtrl;
  logic            rspValid;
  logic            rspReady;
  logic [Xlen-1:0] rspData;

  integer seed;

  // Trace contents, one entry per operation
  logic [NameW-1:0] nameQ[$];
  logic [Xlen-1:0]  aQ[$];
  logic [Xlen-1:0]  bQ[$];
  logic [Xlen-1:0]  expQ[$];
  divCtrlT          ctrlQ[$];

  intDivUnit #(.XLEN(Xlen)) dut0 (
    .clk, .rstN,
    .reqValid, .reqReady, .reqA, .reqB, .reqCtrl,
    .rspValid, .rspReady, .rspData
  );

  always #2 clk = ~clk;                 // 4 ns period

  //////////////////////////////
  // Reporting
  //////////////////////////////
  task automatic stopOnError(input string why);
    $display("%0s", why);
    $display(">>> FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic checkValue(input logic [NameW-1:0] name, input logic [Xlen-1:0] expected,
                            input logic [Xlen-1:0] actual);
    if (expected !== actual) begin
      stopOnError($sformatf("** Error: test %0s expected %08h actual %08h",
                            name, expected, actual));
    end
  endtask

  // Single bit to a data-wide word
  function automatic logic [Xlen-1:0] widen(input logic bitIn);
    return {{(Xlen-1){1'b0}}, bitIn};
  endfunction

  //////////////////////////////
  // Trace file
  //////////////////////////////
  task automatic readTrace();
    integer           fd;
    integer           got;
    string            line;
    logic [NameW-1:0] name;
    logic [Xlen-1:0]  a, b, expected;
    int               isRem, isSigned;
    divCtrlT          ctrl;
    fd = $fopen("test/div_trace.txt", "r");
    if (fd == 0) begin
      stopOnError("Could not open the trace file test/div_trace.txt");
    end else begin
      while (!$feof(fd)) begin
        got = $fgets(line, fd);
        if (got > 0 && line.getc(0) != 8'h23) begin   // Skip # lines
          got = $sscanf(line, "%s %h %h %d %d %h", name, a, b, isRem, isSigned, expected);
          if (got == 6) begin
            ctrl.isRem    = (isRem != 0);
            ctrl.isSigned = (isSigned != 0);
            nameQ.push_back(name);
            aQ.push_back(a);
            bQ.push_back(b);
            ctrlQ.push_back(ctrl);
            expQ.push_back(expected);
          end
        end
      end
      $fclose(fd);
      if (nameQ.size() == 0) stopOnError("The trace file holds no operations");
    end
  endtask

  //////////////////////////////
  // Request and result ports
  //////////////////////////////
  task automatic sendRequest(input logic [NameW-1:0] name, input logic [Xlen-1:0] a,
                             input logic [Xlen-1:0] b, input divCtrlT ctrl);
    int   waited;
    logic accepted;
    waited   = 0;
    accepted = 1'b0;
    @(posedge clk);
    #1;
    reqValid = 1'b1;
    reqA     = a;
    reqB     = b;
    reqCtrl  = ctrl;
    while (!accepted && waited < ReqTimeout) begin
      @(negedge clk);
      if (reqReady) accepted = 1'b1;     // Transfers on the next edge
      waited++;
    end
    if (!accepted) begin
      stopOnError($sformatf("Timed out waiting for reqReady in test %0s", name));
    end else begin
      @(posedge clk);
      #1;
      reqValid = 1'b0;
      reqA     = ~a;                     // Operands must not be reused
      reqB     = ~b;
    end
  endtask

  task automatic takeResponse(input logic [NameW-1:0] name, input logic [Xlen-1:0] expected);
    int              waited;
    logic            done;
    logic            seen;
    logic [Xlen-1:0] held;
    waited = 0;
    done   = 1'b0;
    seen   = 1'b0;
    held   = '0;
    while (!done && waited < RspTimeout) begin
      @(posedge clk);
      #1;
      rspReady = (($random(seed) & 3) != 0);  // Stall roughly one cycle in four
      @(negedge clk);
      if (rspValid) begin
        checkValue(name, '0, widen(reqReady));  // Busy while holding
        if (seen) begin
          checkValue(name, held, rspData);      // Stable under stall
        end else begin
          held = rspData;
          seen = 1'b1;
        end
        if (rspReady) done = 1'b1;
      end
      waited++;
    end
    if (!done) begin
      stopOnError($sformatf("Timed out waiting for a result in test %0s", name));
    end else begin
      @(posedge clk);                    // Result transfer edge
      #1;
      rspReady = 1'b0;
      checkValue(name, expected, held);
      @(negedge clk);
      checkValue(name, '0, widen(rspValid));  // No second copy
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial begin
    clk      = 1'b0;
    rstN     = 1'b0;
    reqValid = 1'b0;
    reqA     = '0;
    reqB     = '0;
    reqCtrl  = '0;
    rspReady = 1'b0;
    seed     = 32'hb9fd_3f14;
    readTrace();
    repeat (8) @(posedge clk);
    #1;
    rstN = 1'b1;
    @(negedge clk);
    checkValue("reset_rspValid", '0, widen(rspValid));
    checkValue("reset_reqReady", widen(1'b1), widen(reqReady));
    for (int n = 0; n < nameQ.size(); n++) begin
      sendRequest(nameQ[n], aQ[n], bQ[n], ctrlQ[n]);
      takeResponse(nameQ[n], expQ[n]);
    end
    $display(">>> PASS");
    $finish;
  end

endmodule : intDivTb

`default_nettype wire

//--- verilog/intDivUnit.sv
`default_nettype none

module intDivUnit import divPkg::*; #(
  parameter int XLEN = DefaultXlen,
  localparam int ResW = XLEN + 5      // Residual width
) (
  input  logic            clk,
  input  logic            rstN,
  // Request port
  input  logic            reqValid,
  output logic            reqReady,
  input  logic [XLEN-1:0] reqA,       // Dividend
  input  logic [XLEN-1:0] reqB,       // Divisor
  input  divCtrlT         reqCtrl,
  // Result port
  output logic            rspValid,
  input  logic            rspReady,
  output logic [XLEN-1:0] rspData
);

  logic [ResW-1:0] xNorm, dNorm;
  logic [ResW-1:0] ws, wc;
  logic [XLEN:0]   firstU, firstUM;
  logic [XLEN-1:0] aSaved;
  postCtrlT        post;
  cntT             iterCnt, normShift, remCnt;
  logic            special, wZero;
  logic            capture, load, step, outLoad;

  //////////////////////////////
  // Datapath
  //////////////////////////////
  divPreproc #(.XLEN(XLEN)) preproc0 (
    .clk, .rstN, .capture,
    .a(reqA), .b(reqB), .ctrl(reqCtrl),
    .xNorm, .dNorm, .iterCnt, .normShift,
    .special, .post, .aSaved
  );

  divIterator #(.XLEN(XLEN)) iter0 (
    .clk, .rstN, .load, .step,
    .xNorm, .dNorm,
    .ws, .wc, .firstU, .firstUM
  );

  divPostproc #(.XLEN(XLEN)) post0 (
    .clk, .rstN, .outLoad,
    .ws, .wc, .dNorm, .firstU, .firstUM,
    .post, .aSaved, .normShift, .remCnt,
    .wZero, .result(rspData)
  );

  // Sequencer
  divFsm fsm0 (
    .clk, .rstN,
    .reqValid, .reqReady, .rspValid, .rspReady,
    .iterCnt, .special, .wZero,
    .capture, .load, .step, .outLoad, .remCnt
  );

endmodule : intDivUnit

`default_nettype wire

//--- vlog.f
common/divPkg.sv
divider/divPreproc.sv
divider/divIterator.sv
divider/divFsm.sv
divider/divPostproc.sv
verilog/intDivUnit.sv
test/intDivTb.sv
